// ==== bench/snakeChecker.sv ====
// snakeChecker module: game reference model, block reassembly, pixel and score comparison
`default_nettype none
`timescale 1ns/1ps

module snakeChecker
    import snakeBoardPkg::*, snakeDrawPkg::*;
#(
    parameter int BlockSize = 10,
    parameter int SnakeLength = 6
)
(
    input wire Clock,
    input wire reset,
    input wire start,
    input wire keys_t keys,
    input wire colour_t snakeColour,
    input wire xCoord_t pixelX,
    input wire yCoord_t pixelY,
    input wire colour_t pixelColour,
    input wire plot,
    input wire score_t score,
    input wire gameOver,
    output int valueErrors,
    output int otherErrors,
    output logic finished
);

    localparam int BlockPixels = BlockSize * BlockSize;

    // model phases between block batches
    localparam int IdlePhase = 0;
    localparam int ErasePhase = 1;
    localparam int MovePhase = 2;
    localparam int OverPhase = 3;

    // one expected block draw and the score seen while it is drawn
    typedef struct packed {
        int x;
        int y;
        int colour;
        int score;
    } block_t;

    block_t expected[$];
    block_t current;
    int modelX [SnakeLength];
    int modelY [SnakeLength];
    // 0 right, 1 down, 2 up, 3 left, same as the key bits
    int heading;
    int appleIndex;
    int modelScore;
    int bodyColour;
    int phase;
    int pixCount;
    logic earlyOverSeen;

    task automatic reportValue(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        valueErrors++;
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, want);
    endtask

    task automatic pushBlock(input int x, input int y, input int colour);
        block_t b;
        b.x = x;
        b.y = y;
        b.colour = colour;
        b.score = modelScore;
        expected.push_back(b);
    endtask

    // head first
    task automatic pushBody(input int colour);
        for (int i = 0; i < SnakeLength; i++)
            pushBlock(modelX[i], modelY[i], colour);
    endtask

    // lowest set key bit wins
    function automatic int keyHeading(input keys_t k);
        int p;
        p = 0;
        for (int i = 3; i >= 0; i--)
        begin
            if (k[i])
                p = i;
        end
        return p;
    endfunction

    // one block step with wraparound, then hit or apple, then redraw
    task automatic moveModel();
        int hx;
        int hy;
        logic hit;
        hx = modelX[0];
        hy = modelY[0];
        case (heading)
            0: hx = (hx + BlockSize) % ScreenWidth;
            1: hy = (hy + BlockSize) % ScreenHeight;
            2: hy = (hy + ScreenHeight - BlockSize) % ScreenHeight;
            default: hx = (hx + ScreenWidth - BlockSize) % ScreenWidth;
        endcase
        for (int i = SnakeLength - 1; i > 0; i--)
        begin
            modelX[i] = modelX[i-1];
            modelY[i] = modelY[i-1];
        end
        modelX[0] = hx;
        modelY[0] = hy;
        hit = 1'b0;
        for (int i = 1; i < SnakeLength; i++)
        begin
            if (modelX[i] == hx && modelY[i] == hy)
                hit = 1'b1;
        end
        if (hit)
        begin
            pushBlock(hx, hy, int'(GameOverColour));
            phase = OverPhase;
        end
        else
        begin
            if (hx == int'(AppleTableX[appleIndex]) && hy == int'(AppleTableY[appleIndex]))
            begin
                pushBlock(int'(AppleTableX[appleIndex]), int'(AppleTableY[appleIndex]),
                          int'(EraseColour));
                appleIndex = (appleIndex + 1) % 8;
                modelScore = (modelScore + 1) % 16;
                pushBlock(int'(AppleTableX[appleIndex]), int'(AppleTableY[appleIndex]),
                          int'(AppleColour));
            end
            pushBody(bodyColour);
            phase = ErasePhase;
        end
    endtask

    // blocks of a frame are generated as its first pixel shows up
    task automatic checkPixel();
        int col;
        int row;
        if (pixCount == 0)
        begin
            if (expected.size() == 0 && phase == ErasePhase)
            begin
                pushBody(int'(EraseColour));
                phase = MovePhase;
            end
            else if (expected.size() == 0 && phase == MovePhase)
                moveModel();
            if (expected.size() == 0)
            begin
                otherErrors++;
                $display("unexpected pixel at %0t, (%0d,%0d) colour %0d, no block pending",
                         $time, pixelX, pixelY, pixelColour);
                return;
            end
            current = expected.pop_front();
            if (score !== score_t'(current.score))
                reportValue("score", score, current.score);
        end
        // columns innermost
        col = pixCount % BlockSize;
        row = pixCount / BlockSize;
        if (pixelX !== xCoord_t'(current.x + col))
            reportValue("pixelX", pixelX, current.x + col);
        if (pixelY !== yCoord_t'(current.y + row))
            reportValue("pixelY", pixelY, current.y + row);
        if (pixelColour !== colour_t'(current.colour))
            reportValue("pixelColour", pixelColour, current.colour);
        pixCount = (pixCount + 1) % BlockPixels;
    endtask

    // outputs are settled at the falling edge
    always @(negedge Clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < SnakeLength; i++)
            begin
                modelX[i] = int'(StartX);
                modelY[i] = int'(StartY) + i * BlockSize;
            end
            expected.delete();
            heading = 2;
            appleIndex = 0;
            modelScore = 0;
            phase = IdlePhase;
            pixCount = 0;
            earlyOverSeen = 1'b0;
            valueErrors = 0;
            otherErrors = 0;
            finished = 1'b0;
        end
        else
        begin
            if (keys != '0)
                heading = keyHeading(keys);
            // quiet outputs until the game starts
            if (phase == IdlePhase)
            begin
                if (plot !== 1'b0)
                    reportValue("plot", plot, 0);
                if (gameOver !== 1'b0)
                    reportValue("gameOver", gameOver, 0);
                if (score !== '0)
                    reportValue("score", score, 0);
                if (start)
                begin
                    bodyColour = int'(snakeColour);
                    pushBlock(int'(AppleTableX[0]), int'(AppleTableY[0]), int'(AppleColour));
                    pushBody(bodyColour);
                    phase = ErasePhase;
                end
            end
            if (gameOver && !earlyOverSeen &&
                !(phase == OverPhase && expected.size() == 0 && pixCount == 0))
            begin
                earlyOverSeen = 1'b1;
                otherErrors++;
                $display("gameOver went high at %0t while the game was still running", $time);
            end
            if (plot)
                checkPixel();
            finished = (phase == OverPhase) && (expected.size() == 0) && (pixCount == 0);
        end
    end

endmodule

`default_nettype wire

// ==== bench/snakeGameTb.sv ====
// testbench top with clock, reset, LCG steering stimulus, timeout and final verdict
`default_nettype none
`timescale 1ns/1ps

module snakeGameTb
    import snakeBoardPkg::*, snakeDrawPkg::*;
#(
    parameter int BlockSize = 10,
    parameter int SnakeLength = 6,
    parameter int FrameTicks = 500
);

    localparam int ReverseFrame = 60;
    // twice 62 frames of erase, apple swap, redraw and frame wait
    localparam int TimeoutCycles =
        2 * 62 * ((2 * SnakeLength + 3) * BlockSize * BlockSize + FrameTicks);

    logic Clock;
    logic reset;
    logic start;
    keys_t keys;
    colour_t snakeColour;
    xCoord_t pixelX;
    yCoord_t pixelY;
    colour_t pixelColour;
    logic plot;
    score_t score;
    logic gameOver;

    int valueErrors;
    int otherErrors;
    int flowErrors;
    logic finished;

    int unsigned rngState;
    int unsigned firstDraw;
    int cycles = 0;
    int frames;
    // 0 right, 1 down, 2 up, 3 left
    int heading;
    xCoord_t headX;
    yCoord_t headY;
    xCoord_t appleX = '0;
    yCoord_t appleY = '0;
    logic applePrev = 1'b0;
    logic steered;

    snakeGame #(
        .BlockSize(BlockSize),
        .SnakeLength(SnakeLength),
        .FrameTicks(FrameTicks)
    ) DUT (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .keys(keys),
        .snakeColour(snakeColour),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .plot(plot),
        .score(score),
        .gameOver(gameOver)
    );

    snakeChecker #(
        .BlockSize(BlockSize),
        .SnakeLength(SnakeLength)
    ) blockCheck (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .keys(keys),
        .snakeColour(snakeColour),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .plot(plot),
        .score(score),
        .gameOver(gameOver),
        .valueErrors(valueErrors),
        .otherErrors(otherErrors),
        .finished(finished)
    );

    initial
    begin
        Clock = 1'b0;
        forever #50 Clock = ~Clock;
    end

    function automatic int unsigned lcgNext(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // upper LCG bits are the better ones
    task automatic drawRandom(output int unsigned r);
        rngState = lcgNext(rngState);
        r = rngState >> 16;
    endtask

    // x distance first, then y
    function automatic int towardApple();
        if (appleX > headX)
            return 0;
        if (appleX < headX)
            return 3;
        if (appleY > headY)
            return 1;
        return 2;
    endfunction

    // apple origin is the first pixel of each apple block
    always @(negedge Clock)
    begin
        if (plot && pixelColour == AppleColour && !applePrev)
        begin
            appleX <= pixelX;
            appleY <= pixelY;
        end
        applePrev <= plot && pixelColour == AppleColour;
    end

    always @(posedge Clock)
    begin
        cycles = cycles + 1;
        if (cycles >= TimeoutCycles)
        begin
            $display("timeout: game not over after %0d cycles", cycles);
            $display("errors: value %0d, other %0d", valueErrors, otherErrors + flowErrors);
            $display(">>> FAIL");
            $finish;
        end
    end

    // steer, release, or reverse once enough frames have run
    task automatic steerKeys();
        int unsigned r;
        int d;
        drawRandom(r);
        if (frames >= ReverseFrame)
            keys = keys_t'(1 << (3 - heading));
        else if (frames > 0 && r % 8 == 7)
            keys = '0;
        else
        begin
            if (r % 8 < 6)
                d = towardApple();
            else
                d = (r >> 3) % 4;
            // turn aside instead of onto the neck
            if (d == 3 - heading)
                d = (d == 0 || d == 3) ? ((appleY >= headY) ? 1 : 2) : 0;
            // extra lower-priority keys exercise the priority order
            keys = keys_t'((1 << d) | ((r >> 5) & (15 << (d + 1)) & 15));
            heading = d;
        end
        frames++;
    endtask

    initial
    begin
        reset = 1'b1;
        start = 1'b0;
        keys = '0;
        rngState = 75886;
        frames = 0;
        heading = 2;
        steered = 1'b0;
        flowErrors = 0;
        // any colour but black, red and magenta
        drawRandom(firstDraw);
        snakeColour = colour_t'(firstDraw % 5 + 1);
        if (snakeColour >= 3'd4)
            snakeColour = snakeColour + 3'd2;
        repeat (8) @(posedge Clock);
        #10 reset = 1'b0;
        repeat (4) @(posedge Clock);
        #10 start = 1'b1;
        @(posedge Clock);
        #10 start = 1'b0;
        while (!gameOver)
        begin
            @(negedge Clock);
            // first snake pixel of a frame is the new head origin
            if (plot && pixelColour == snakeColour && !steered)
            begin
                headX = pixelX;
                headY = pixelY;
                steered = 1'b1;
                @(posedge Clock);
                #10;
                steerKeys();
            end
            else if (plot && pixelColour == EraseColour)
                steered = 1'b0;
        end
        // nothing may be plotted after the end
        repeat (3 * BlockSize * BlockSize) @(negedge Clock);
        if (!gameOver)
        begin
            flowErrors++;
            $display("gameOver dropped after the game had ended");
        end
        if (!finished)
        begin
            flowErrors++;
            $display("game ended before all expected blocks were drawn");
        end
        $display("errors: value %0d, other %0d", valueErrors, otherErrors + flowErrors);
        if (valueErrors == 0 && otherErrors == 0 && flowErrors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/applePlacer.sv ====
// applePlacer module: apple position from the table, eaten test and score counter
`default_nettype none
`timescale 1ns/1ps

module applePlacer
    import snakeBoardPkg::*;
(
    input wire Clock,
    input wire reset,
    input wire xCoord_t headX,
    input wire yCoord_t headY,
    input wire relocate,
    output xCoord_t appleX,
    output yCoord_t appleY,
    output logic appleEaten,
    output score_t score
);

    // table entry in use, wraps after the eighth
    logic [2:0] tableIndex;

    assign appleX = AppleTableX[tableIndex];
    assign appleY = AppleTableY[tableIndex];

    // head sits exactly on the apple block
    assign appleEaten = (headX == appleX) && (headY == appleY);

    // each relocate moves to the next entry and counts one apple
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            tableIndex <= '0;
            score <= '0;
        end
        else if (relocate)
        begin
            tableIndex <= tableIndex + 1'b1;
            score <= score + 1'b1;
        end
    end

    // the sequencer only moves an apple that was really eaten
    relocateOnlyWhenEaten: assert property (@(posedge Clock) disable iff (reset)
        relocate |-> appleEaten);

endmodule

`default_nettype wire

// ==== rtl/blockRaster.sv ====
// blockRaster module: walks the pixels of one block and drives the plot port
`default_nettype none
`timescale 1ns/1ps

module blockRaster
    import snakeBoardPkg::*, snakeDrawPkg::*;
#(
    parameter int BlockSize = 10
)
(
    input wire Clock,
    input wire reset,
    input wire drawStart,
    input wire xCoord_t originX,
    input wire yCoord_t originY,
    input wire colour_t drawColour,
    output xCoord_t pixelX,
    output yCoord_t pixelY,
    output colour_t pixelColour,
    output logic plot,
    output logic blockDone
);

    localparam int OffsetBits = $clog2(BlockSize + 1);
    localparam logic [OffsetBits-1:0] LastOffset = OffsetBits'(BlockSize - 1);

    xCoord_t baseX;
    yCoord_t baseY;
    colour_t baseColour;
    logic [OffsetBits-1:0] colOffset;
    logic [OffsetBits-1:0] rowOffset;
    logic lastCol;
    logic lastRow;

    // block origin and colour held for the whole block
    always_ff @(posedge Clock)
    begin
        if (drawStart)
        begin
            baseX <= originX;
            baseY <= originY;
            baseColour <= drawColour;
        end
    end

    assign lastCol = (colOffset == LastOffset);
    assign lastRow = (rowOffset == LastOffset);
    assign blockDone = plot && lastCol && lastRow;

    // columns innermost; a start on the last pixel restarts with no gap
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            plot <= 1'b0;
            colOffset <= '0;
            rowOffset <= '0;
        end
        else if (drawStart)
        begin
            plot <= 1'b1;
            colOffset <= '0;
            rowOffset <= '0;
        end
        else if (plot)
        begin
            if (lastCol)
            begin
                colOffset <= '0;
                rowOffset <= lastRow ? '0 : rowOffset + 1'b1;
                plot <= !lastRow;
            end
            else
                colOffset <= colOffset + 1'b1;
        end
    end

    assign pixelX = baseX + xCoord_t'(colOffset);
    assign pixelY = baseY + yCoord_t'(rowOffset);
    assign pixelColour = baseColour;

    // no new block while one is running, except on its last pixel
    noOverlappedStart: assert property (@(posedge Clock) disable iff (reset)
        drawStart && plot |-> blockDone);

endmodule

`default_nettype wire

// ==== rtl/snakeBoardPkg.sv ====
// board geometry, coordinate and key types, start position, apple table, score type
`default_nettype none

package snakeBoardPkg;

    // pixel addresses on the 160x120 board
    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;

    localparam int ScreenWidth = 160;
    localparam int ScreenHeight = 120;

    // active-high keys, bit 0 right, bit 1 down, bit 2 up, bit 3 left
    typedef logic [3:0] keys_t;

    // heading encoding follows the key bit order
    typedef enum logic [1:0] {DirRight, DirDown, DirUp, DirLeft} direction_t;

    // head start, body trails below it
    localparam xCoord_t StartX = 8'd80;
    localparam yCoord_t StartY = 7'd60;

    // apple positions, visited in order and wrapping after eight
    localparam xCoord_t AppleTableX [8] = '{8'd30, 8'd10, 8'd70, 8'd60,
                                            8'd20, 8'd50, 8'd80, 8'd120};
    localparam yCoord_t AppleTableY [8] = '{7'd30, 7'd20, 7'd90, 7'd100,
                                            7'd80, 7'd10, 7'd50, 7'd40};

    // apples eaten, wraps at 16
    typedef logic [3:0] score_t;

endpackage

`default_nettype wire

// ==== rtl/snakeBody.sv ====
// snakeBody module: heading register, segment shift with board wraparound, self-hit test
`default_nettype none
`timescale 1ns/1ps

module snakeBody
    import snakeBoardPkg::*;
#(
    parameter int BlockSize = 10,
    parameter int SnakeLength = 6
)
(
    input wire Clock,
    input wire reset,
    input wire keys_t keys,
    input wire advance,
    output xCoord_t [SnakeLength-1:0] bodyX,
    output yCoord_t [SnakeLength-1:0] bodyY,
    output logic directionValid,
    output logic headHit
);

    // one block step, and the last block origin before the wrap
    localparam xCoord_t StepX = xCoord_t'(BlockSize);
    localparam yCoord_t StepY = yCoord_t'(BlockSize);
    localparam xCoord_t LastX = xCoord_t'(ScreenWidth - BlockSize);
    localparam yCoord_t LastY = yCoord_t'(ScreenHeight - BlockSize);

    direction_t heading;
    xCoord_t nextHeadX;
    yCoord_t nextHeadY;

    // priority right, down, up, left; no key keeps the heading
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            heading <= DirUp;
            directionValid <= 1'b0;
        end
        else if (keys != '0)
        begin
            directionValid <= 1'b1;
            if (keys[0])
                heading <= DirRight;
            else if (keys[1])
                heading <= DirDown;
            else if (keys[2])
                heading <= DirUp;
            else
                heading <= DirLeft;
        end
    end

    // head one block along the heading, wrapping at the board edges
    always_comb
    begin
        nextHeadX = bodyX[0];
        nextHeadY = bodyY[0];
        case (heading)
            DirRight:
                nextHeadX = (bodyX[0] >= LastX) ? bodyX[0] - LastX : bodyX[0] + StepX;
            DirLeft:
                nextHeadX = (bodyX[0] < StepX) ? bodyX[0] + LastX : bodyX[0] - StepX;
            DirDown:
                nextHeadY = (bodyY[0] >= LastY) ? bodyY[0] - LastY : bodyY[0] + StepY;
            default:
                nextHeadY = (bodyY[0] < StepY) ? bodyY[0] + LastY : bodyY[0] - StepY;
        endcase
    end

    // vertical column at reset, head on top
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < SnakeLength; i++)
            begin
                bodyX[i] <= StartX;
                bodyY[i] <= yCoord_t'(StartY + i * BlockSize);
            end
        end
        else if (advance)
        begin
            // each segment takes its predecessor's block
            for (int i = SnakeLength - 1; i > 0; i--)
            begin
                bodyX[i] <= bodyX[i-1];
                bodyY[i] <= bodyY[i-1];
            end
            bodyX[0] <= nextHeadX;
            bodyY[0] <= nextHeadY;
        end
    end

    // grid-aligned, so overlap is plain equality
    always_comb
    begin
        headHit = 1'b0;
        for (int i = 1; i < SnakeLength; i++)
        begin
            if (bodyX[i] == bodyX[0] && bodyY[i] == bodyY[0])
                headHit = 1'b1;
        end
    end

    // wrap arithmetic keeps the head on the board
    headOnBoard: assert property (@(posedge Clock) disable iff (reset)
        advance |=> (bodyX[0] < ScreenWidth) && (bodyY[0] < ScreenHeight));

endmodule

`default_nettype wire

// ==== rtl/snakeDrawPkg.sv ====
// colour type, fixed draw colours and the game sequencer state enum
`default_nettype none

package snakeDrawPkg;

    // 3-bit rgb pixel colour
    typedef logic [2:0] colour_t;

    localparam colour_t AppleColour = 3'd4;
    localparam colour_t EraseColour = 3'd0;
    localparam colour_t GameOverColour = 3'd5;

    // game flow, one state per kind of block being drawn
    typedef enum logic [3:0] {
        waitStart, drawApple, drawInitial, waitKey, waitFrame,
        eraseBody, moveSnake, judge, eraseApple, drawNewApple,
        drawBody, endGame, halted
    } sequencerState_t;

endpackage

`default_nettype wire

// ==== rtl/snakeGame.sv ====
// snakeGame top module: connects body, apple, raster and sequencer blocks
`default_nettype none
`timescale 1ns/1ps

module snakeGame
    import snakeBoardPkg::*, snakeDrawPkg::*;
#(
    parameter int BlockSize = 10,
    parameter int SnakeLength = 6,
    parameter int FrameTicks = 1000000
)
(
    input wire Clock,
    input wire reset,
    input wire start,
    input wire keys_t keys,
    input wire colour_t snakeColour,
    output xCoord_t pixelX,
    output yCoord_t pixelY,
    output colour_t pixelColour,
    output logic plot,
    output score_t score,
    output logic gameOver
);

    // segment positions, head at index 0
    xCoord_t [SnakeLength-1:0] bodyX;
    yCoord_t [SnakeLength-1:0] bodyY;
    logic directionValid;
    logic headHit;
    logic advance;

    // apple side
    xCoord_t appleX;
    yCoord_t appleY;
    logic appleEaten;
    logic relocate;

    // block request to the raster
    logic drawStart;
    xCoord_t originX;
    yCoord_t originY;
    colour_t drawColour;
    logic blockDone;

    snakeBody #(
        .BlockSize(BlockSize),
        .SnakeLength(SnakeLength)
    ) body (
        .Clock(Clock),
        .reset(reset),
        .keys(keys),
        .advance(advance),
        .bodyX(bodyX),
        .bodyY(bodyY),
        .directionValid(directionValid),
        .headHit(headHit)
    );

    applePlacer apple (
        .Clock(Clock),
        .reset(reset),
        .headX(bodyX[0]),
        .headY(bodyY[0]),
        .relocate(relocate),
        .appleX(appleX),
        .appleY(appleY),
        .appleEaten(appleEaten),
        .score(score)
    );

    blockRaster #(
        .BlockSize(BlockSize)
    ) raster (
        .Clock(Clock),
        .reset(reset),
        .drawStart(drawStart),
        .originX(originX),
        .originY(originY),
        .drawColour(drawColour),
        .pixelX(pixelX),
        .pixelY(pixelY),
        .pixelColour(pixelColour),
        .plot(plot),
        .blockDone(blockDone)
    );

    snakeSequencer #(
        .SnakeLength(SnakeLength),
        .FrameTicks(FrameTicks)
    ) sequencer (
        .Clock(Clock),
        .reset(reset),
        .start(start),
        .directionValid(directionValid),
        .headHit(headHit),
        .appleEaten(appleEaten),
        .bodyX(bodyX),
        .bodyY(bodyY),
        .appleX(appleX),
        .appleY(appleY),
        .snakeColour(snakeColour),
        .blockDone(blockDone),
        .advance(advance),
        .relocate(relocate),
        .drawStart(drawStart),
        .originX(originX),
        .originY(originY),
        .drawColour(drawColour),
        .gameOver(gameOver)
    );

endmodule

`default_nettype wire

// ==== rtl/snakeSequencer.sv ====
// snakeSequencer module: frame timer and game FSM that picks each block to draw
`default_nettype none
`timescale 1ns/1ps

module snakeSequencer
    import snakeBoardPkg::*, snakeDrawPkg::*;
#(
    parameter int SnakeLength = 6,
    parameter int FrameTicks = 1000000
)
(
    input wire Clock,
    input wire reset,
    input wire start,
    input wire directionValid,
    input wire headHit,
    input wire appleEaten,
    input wire xCoord_t [SnakeLength-1:0] bodyX,
    input wire yCoord_t [SnakeLength-1:0] bodyY,
    input wire xCoord_t appleX,
    input wire yCoord_t appleY,
    input wire colour_t snakeColour,
    input wire blockDone,
    output logic advance,
    output logic relocate,
    output logic drawStart,
    output xCoord_t originX,
    output yCoord_t originY,
    output colour_t drawColour,
    output logic gameOver
);

    localparam int TimerBits = $clog2(FrameTicks + 1);
    localparam int IndexBits = (SnakeLength > 1) ? $clog2(SnakeLength) : 1;
    localparam logic [TimerBits-1:0] LastTick = TimerBits'(FrameTicks - 1);
    localparam logic [IndexBits-1:0] LastSegment = IndexBits'(SnakeLength - 1);

    sequencerState_t state;
    sequencerState_t nextState;
    logic [TimerBits-1:0] frameCount;
    logic frameTick;
    logic [IndexBits-1:0] segIndex;
    logic blockBusy;
    logic drawState;
    logic appleBlock;
    logic lastSegment;

    // free-running animation tick
    assign frameTick = (frameCount == LastTick);

    always_ff @(posedge Clock)
    begin
        if (reset || frameTick)
            frameCount <= '0;
        else
            frameCount <= frameCount + 1'b1;
    end

    // states that issue blocks, and which of them target the apple
    assign drawState = state inside {drawApple, drawInitial, eraseBody, eraseApple,
                                     drawNewApple, drawBody, endGame};
    assign appleBlock = state inside {drawApple, eraseApple, drawNewApple};
    assign lastSegment = (segIndex == LastSegment);

    always_comb
    begin
        nextState = state;
        case (state)
            waitStart:
                if (start)
                    nextState = drawApple;
            drawApple:
                if (blockDone)
                    nextState = drawInitial;
            drawInitial:
                if (blockDone && lastSegment)
                    nextState = waitKey;
            waitKey:
                if (directionValid)
                    nextState = waitFrame;
            waitFrame:
                if (frameTick)
                    nextState = eraseBody;
            eraseBody:
                if (blockDone && lastSegment)
                    nextState = moveSnake;
            moveSnake:
                nextState = judge;
            // hit wins over a simultaneous apple
            judge:
                if (headHit)
                    nextState = endGame;
                else if (appleEaten)
                    nextState = eraseApple;
                else
                    nextState = drawBody;
            eraseApple:
                if (blockDone)
                    nextState = drawNewApple;
            drawNewApple:
                if (blockDone)
                    nextState = drawBody;
            drawBody:
                if (blockDone && lastSegment)
                    nextState = waitFrame;
            endGame:
                if (blockDone)
                    nextState = halted;
            halted:
                nextState = halted;
            default:
                nextState = waitStart;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state <= waitStart;
            segIndex <= '0;
            blockBusy <= 1'b0;
        end
        else
        begin
            state <= nextState;
            // one block in flight at a time
            if (drawStart)
                blockBusy <= 1'b1;
            else if (blockDone)
                blockBusy <= 1'b0;
            // head first in every body pass
            if (nextState != state)
                segIndex <= '0;
            else if (blockDone && !appleBlock)
                segIndex <= segIndex + 1'b1;
        end
    end

    // next block once the raster is idle again
    assign drawStart = drawState && !blockBusy;
    assign originX = appleBlock ? appleX : bodyX[segIndex];
    assign originY = appleBlock ? appleY : bodyY[segIndex];

    always_comb
    begin
        case (state)
            drawApple, drawNewApple:
                drawColour = AppleColour;
            eraseBody, eraseApple:
                drawColour = EraseColour;
            endGame:
                drawColour = GameOverColour;
            default:
                drawColour = snakeColour;
        endcase
    end

    // advance one cycle, apple moves as its erase completes
    assign advance = (state == moveSnake);
    assign relocate = (state == eraseApple) && blockDone;
    assign gameOver = (state == halted);

    // only reset leaves the halted game
    gameOverSticky: assert property (@(posedge Clock) disable iff (reset)
        gameOver |=> gameOver);

endmodule

`default_nettype wire

// ==== runSim.sh ====
#!/usr/bin/env bash
# build the snake game testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal --top-module snakeGameTb \
        -f snakeGame.f -o snakeSim &&
    ./obj_dir/snakeSim | tee /dev/stderr | grep -qx ">>> PASS" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// ==== snakeGame.f ====
rtl/snakeBoardPkg.sv
rtl/snakeDrawPkg.sv
rtl/snakeBody.sv
rtl/applePlacer.sv
rtl/blockRaster.sv
rtl/snakeSequencer.sv
rtl/snakeGame.sv
bench/snakeChecker.sv
bench/snakeGameTb.sv
